// File: source/ifu_params.svh
// cache geometry and fetch constants, included by the package and any RTL that needs them
`ifndef IFU_PARAMS_SVH
`define IFU_PARAMS_SVH

// associativity of the instruction cache
`define IFU_NUM_WAYS 2

// sets per way
`define IFU_NUM_SETS 64

// 32-bit words in one line, 16 bytes
`define IFU_WORDS_PER_LINE 4

// first fetch address after reset
`define IFU_RESET_PC 32'h8000_0000

// start value of the replacement lfsr, never zero
`define IFU_LFSR_SEED 16'hace1

// addi x0, x0, 0
`define IFU_NOP 32'h0000_0013

`endif

// File: source/ifu_pkg.sv
// shared fetch unit types and address helpers, compiled ahead of every RTL file
`include "ifu_params.svh"

package ifu_pkg;

    localparam int INDEX_W = $clog2(`IFU_NUM_SETS);
    localparam int OFFSET_W = $clog2(`IFU_WORDS_PER_LINE);
    // byte offset bits inside one line
    localparam int LINE_OFF_W = OFFSET_W + 2;
    localparam int TAG_W = 32 - INDEX_W - LINE_OFF_W;

    typedef logic [31:0] word_t;
    typedef word_t [`IFU_WORDS_PER_LINE-1:0] line_t;
    typedef logic [INDEX_W-1:0] index_t;
    typedef logic [OFFSET_W-1:0] offset_t;
    typedef logic [TAG_W-1:0] tag_t;

    typedef struct packed {
        tag_t tag;
        logic valid;
    } meta_t;

    typedef logic [$clog2(`IFU_NUM_WAYS)-1:0] way_t;
    typedef logic [`IFU_NUM_WAYS-1:0] way_mask_t;

    typedef enum logic [2:0] {
        CLEARING,
        IDLE,
        WAIT_ARREADY,
        RECEIVING,
        REFILL,
        FLUSH_WAIT_ARREADY,
        FLUSH_RECEIVING
    } fetch_state_t;

    function automatic index_t index_of(input word_t addr);
        return addr[LINE_OFF_W +: INDEX_W];
    endfunction

    function automatic tag_t tag_of(input word_t addr);
        return addr[31 -: TAG_W];
    endfunction

    function automatic offset_t offset_of(input word_t addr);
        return addr[2 +: OFFSET_W];
    endfunction

    // address of the first byte of the line
    function automatic word_t line_base(input word_t addr);
        return {addr[31:LINE_OFF_W], {LINE_OFF_W{1'b0}}};
    endfunction

endpackage

// File: source/icache_wr_if.sv
// cache write command from the refill controller to the cache store, for clears and refills
`timescale 1ns/1ns

interface icache_wr_if;
    import ifu_pkg::*;

    // one enable per way, meta and data written together
    way_mask_t wen;
    index_t    index;
    // valid low while clearing, high on a refill
    meta_t     meta;
    line_t     line;

    modport ctrl (
        output wen,
        output index,
        output meta,
        output line
    );

    modport store (
        input wen,
        input index,
        input meta,
        input line
    );

endinterface

// File: source/sync_ram.sv
// simple dual-port ram with registered read, used for both cache meta and cache data
`timescale 1ns/1ns
`include "ifu_params.svh"

module sync_ram #(
    parameter type entry_t = logic,
    parameter int  DEPTH   = `IFU_NUM_SETS
) (
    input  logic            clk,
    input  logic            wen,
    input  ifu_pkg::index_t waddr,
    input  entry_t          wdata,
    input  ifu_pkg::index_t raddr,
    output entry_t          rdata
);

    entry_t mem [DEPTH];

    // write port
    always_ff @(posedge clk) begin
        if (wen) begin
            mem[waddr] <= wdata;
        end
    end

    // read port, old contents on a same-address write
    always_ff @(posedge clk) begin
        rdata <= mem[raddr];
    end

endmodule

// File: source/icache_store.sv
// instruction cache ways with write forwarding, hit check and victim choice for the fetch pipe
`timescale 1ns/1ns
`include "ifu_params.svh"

module icache_store (
    input  logic            clk,
    input  logic            rst,
    icache_wr_if.store      wr,
    input  ifu_pkg::index_t raddr,
    input  ifu_pkg::word_t  rd_pc,
    output logic            hit,
    output ifu_pkg::word_t  hit_word,
    output ifu_pkg::way_t   victim
);
    import ifu_pkg::*;

    meta_t [`IFU_NUM_WAYS-1:0] meta_ram;
    meta_t [`IFU_NUM_WAYS-1:0] meta_rd;
    line_t [`IFU_NUM_WAYS-1:0] line_ram;
    line_t [`IFU_NUM_WAYS-1:0] line_rd;
    way_mask_t                 way_hit;
    // ways written at the address read in the same cycle
    way_mask_t                 fwd_q;
    meta_t                     fwd_meta;
    line_t                     fwd_line;
    logic [15:0]               lfsr;

    for (genvar w = 0; w < `IFU_NUM_WAYS; w++) begin : g_way
        sync_ram #(
            .entry_t(meta_t),
            .DEPTH(`IFU_NUM_SETS)
        ) u_meta (
            .clk(clk),
            .wen(wr.wen[w]),
            .waddr(wr.index),
            .wdata(wr.meta),
            .raddr(raddr),
            .rdata(meta_ram[w])
        );

        sync_ram #(
            .entry_t(line_t),
            .DEPTH(`IFU_NUM_SETS)
        ) u_line (
            .clk(clk),
            .wen(wr.wen[w]),
            .waddr(wr.index),
            .wdata(wr.line),
            .raddr(raddr),
            .rdata(line_ram[w])
        );

        // newest first: write in flight, then write that raced the read
        always_comb begin
            if (wr.wen[w] && wr.index == index_of(rd_pc)) begin
                meta_rd[w] = wr.meta;
                line_rd[w] = wr.line;
            end else if (fwd_q[w]) begin
                meta_rd[w] = fwd_meta;
                line_rd[w] = fwd_line;
            end else begin
                meta_rd[w] = meta_ram[w];
                line_rd[w] = line_ram[w];
            end
        end

        assign way_hit[w] = meta_rd[w].valid && meta_rd[w].tag == tag_of(rd_pc);
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            fwd_q <= '0;
        end else begin
            fwd_q <= wr.wen & {`IFU_NUM_WAYS{wr.index == raddr}};
        end
    end

    always_ff @(posedge clk) begin
        fwd_meta <= wr.meta;
        fwd_line <= wr.line;
    end

    assign hit = |way_hit;

    always_comb begin
        hit_word = '0;
        for (int w = 0; w < `IFU_NUM_WAYS; w++) begin
            if (way_hit[w]) begin
                hit_word = line_rd[w][offset_of(rd_pc)];
            end
        end
    end

    // lowest empty way wins, else random
    always_comb begin
        victim = lfsr[$bits(way_t)-1:0];
        for (int w = `IFU_NUM_WAYS - 1; w >= 0; w--) begin
            if (!meta_rd[w].valid) begin
                victim = way_t'(w);
            end
        end
    end

    // x^16 + x^14 + x^13 + x^11, one step per refill
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lfsr <= `IFU_LFSR_SEED;
        end else if (|wr.wen && wr.meta.valid) begin
            lfsr <= {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
        end
    end

endmodule

// File: source/fetch_pipe.sv
// fetch pipeline with pc register, cache read stage and output stage feeding the decoder
`timescale 1ns/1ns
`include "ifu_params.svh"

module fetch_pipe (
    input  logic            clk,
    input  logic            rst,
    input  logic            flush,
    input  ifu_pkg::word_t  redirect_pc,
    input  logic            stall,
    output ifu_pkg::index_t rd_index,
    output ifu_pkg::word_t  rd_pc,
    input  logic            hit,
    input  ifu_pkg::word_t  hit_word,
    input  ifu_pkg::way_t   victim,
    input  ifu_pkg::line_t  refill_line,
    output ifu_pkg::word_t  out_pc,
    output logic            out_valid,
    output logic            out_hit,
    output ifu_pkg::way_t   out_victim,
    output ifu_pkg::word_t  fetch_pc,
    output ifu_pkg::word_t  fetch_inst,
    output logic            fetch_valid
);
    import ifu_pkg::*;

    word_t pc;
    word_t npc;
    logic  rd_valid;
    word_t out_word;

    // no prediction, redirect or fall through
    assign npc = flush ? redirect_pc : pc + 32'd4;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc <= `IFU_RESET_PC;
        end else if (flush || !stall) begin
            pc <= npc;
        end
    end

    // while held, re-read the line of rd_pc so the ram output keeps matching it
    assign rd_index = stall ? index_of(rd_pc) : index_of(pc);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_valid  <= 1'b0;
            rd_pc     <= '0;
            out_valid <= 1'b0;
            out_hit   <= 1'b0;
            out_pc    <= '0;
        end else begin
            if (flush) begin
                rd_valid  <= 1'b0;
                out_valid <= 1'b0;
            end else if (!stall) begin
                rd_valid  <= 1'b1;
                out_valid <= rd_valid;
            end
            if (!stall) begin
                rd_pc   <= pc;
                out_pc  <= rd_pc;
                out_hit <= hit;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            out_word   <= hit_word;
            out_victim <= victim;
        end
    end

    assign fetch_pc = out_pc;

    // a miss shows only once its line has landed and the pipe may move
    assign fetch_valid = out_valid && !flush && (out_hit || !stall);

    assign fetch_inst = !fetch_valid ? `IFU_NOP :
                        out_hit ? out_word : refill_line[offset_of(out_pc)];

endmodule

// File: source/refill_ctrl.sv
// refill controller that clears the cache after reset and fetches missing lines over the burst bus
`timescale 1ns/1ns
`include "ifu_params.svh"

module refill_ctrl (
    input  logic           clk,
    input  logic           rst,
    input  logic           flush,
    input  logic           cpu_busy,
    input  ifu_pkg::word_t out_pc,
    input  logic           out_valid,
    input  logic           out_hit,
    input  ifu_pkg::way_t  out_victim,
    icache_wr_if.ctrl      wr,
    output ifu_pkg::line_t refill_line,
    output logic           busy,
    output logic           bus_arvalid,
    input  logic           bus_arready,
    output ifu_pkg::word_t bus_araddr,
    output logic [3:0]     bus_rlen,
    input  logic           bus_rvalid,
    input  ifu_pkg::word_t bus_rdata,
    input  logic           bus_rlast,
    output logic           bus_rready
);
    import ifu_pkg::*;

    fetch_state_t state;
    fetch_state_t next;
    index_t       clr_idx;
    offset_t      beat;
    // refilled word still waiting for the cpu to take it
    logic         refill_held;
    logic         beat_ok;
    logic         last_ok;

    // address stays put while waiting, the pipe is stalled by busy
    assign bus_arvalid = (state == WAIT_ARREADY) || (state == FLUSH_WAIT_ARREADY);
    assign bus_araddr  = line_base(out_pc);
    assign bus_rlen    = 4'(`IFU_WORDS_PER_LINE);
    assign bus_rready  = (state == RECEIVING) || (state == FLUSH_RECEIVING);
    assign beat_ok     = bus_rvalid && bus_rready;
    assign last_ok     = beat_ok && bus_rlast;

    always_comb begin
        next = state;
        case (state)
            CLEARING: begin
                if (&clr_idx) begin
                    next = IDLE;
                end
            end
            IDLE: begin
                if (out_valid && !out_hit && !refill_held && !flush) begin
                    next = WAIT_ARREADY;
                end
            end
            WAIT_ARREADY: begin
                if (bus_arready) begin
                    next = flush ? FLUSH_RECEIVING : RECEIVING;
                end else if (flush) begin
                    next = FLUSH_WAIT_ARREADY;
                end
            end
            RECEIVING: begin
                if (last_ok) begin
                    next = flush ? IDLE : REFILL;
                end else if (flush) begin
                    next = FLUSH_RECEIVING;
                end
            end
            REFILL: next = IDLE;
            // request already on the bus, finish it and drop the data
            FLUSH_WAIT_ARREADY: begin
                if (bus_arready) begin
                    next = FLUSH_RECEIVING;
                end
            end
            FLUSH_RECEIVING: begin
                if (last_ok) begin
                    next = IDLE;
                end
            end
            default: next = IDLE;
        endcase
    end

    assign busy = (next != IDLE);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state       <= CLEARING;
            clr_idx     <= '0;
            beat        <= '0;
            refill_held <= 1'b0;
        end else begin
            state <= next;
            if (state == CLEARING) begin
                clr_idx <= clr_idx + 1'b1;
            end
            if (bus_arvalid && bus_arready) begin
                beat <= '0;
            end else if (state == RECEIVING && beat_ok) begin
                beat <= beat + 1'b1;
            end
            refill_held <= (state == REFILL || refill_held) && cpu_busy && !flush;
        end
    end

    // burst assembly
    always_ff @(posedge clk) begin
        if (state == RECEIVING && beat_ok) begin
            refill_line[beat] <= bus_rdata;
        end
    end

    // clear every way of a set per cycle, or write the refilled line to the victim
    assign wr.index = (state == CLEARING) ? clr_idx : index_of(out_pc);
    assign wr.meta  = '{tag: tag_of(out_pc), valid: state == REFILL};
    assign wr.line  = refill_line;

    always_comb begin
        wr.wen = '0;
        if (state == CLEARING) begin
            wr.wen = '1;
        end else if (state == REFILL) begin
            wr.wen[out_victim] = 1'b1;
        end
    end

endmodule

// File: source/fetch_unit.sv
// instruction fetch unit top level, pc pipeline plus cache and burst bus refill
`timescale 1ns/1ns

module fetch_unit (
    input  logic           clk,
    input  logic           rst,
    input  logic           flush,
    input  ifu_pkg::word_t redirect_pc,
    input  logic           cpu_busy,
    output ifu_pkg::word_t fetch_pc,
    output ifu_pkg::word_t fetch_inst,
    output logic           fetch_valid,
    output logic           fetch_busy,
    output logic           bus_arvalid,
    input  logic           bus_arready,
    output ifu_pkg::word_t bus_araddr,
    output logic [3:0]     bus_rlen,
    input  logic           bus_rvalid,
    input  ifu_pkg::word_t bus_rdata,
    input  logic           bus_rlast,
    output logic           bus_rready
);
    import ifu_pkg::*;

    index_t rd_index;
    word_t  rd_pc;
    logic   hit;
    word_t  hit_word;
    way_t   victim;
    line_t  refill_line;
    word_t  out_pc;
    logic   out_valid;
    logic   out_hit;
    way_t   out_victim;
    logic   stall;

    icache_wr_if wr_bus ();

    // a refill or the cpu holds every stage
    assign stall = fetch_busy | cpu_busy;

    fetch_pipe u_fetch_pipe (
        .clk(clk),
        .rst(rst),
        .flush(flush),
        .redirect_pc(redirect_pc),
        .stall(stall),
        .rd_index(rd_index),
        .rd_pc(rd_pc),
        .hit(hit),
        .hit_word(hit_word),
        .victim(victim),
        .refill_line(refill_line),
        .out_pc(out_pc),
        .out_valid(out_valid),
        .out_hit(out_hit),
        .out_victim(out_victim),
        .fetch_pc(fetch_pc),
        .fetch_inst(fetch_inst),
        .fetch_valid(fetch_valid)
    );

    icache_store u_icache_store (
        .clk(clk),
        .rst(rst),
        .wr(wr_bus.store),
        .raddr(rd_index),
        .rd_pc(rd_pc),
        .hit(hit),
        .hit_word(hit_word),
        .victim(victim)
    );

    refill_ctrl u_refill_ctrl (
        .clk(clk),
        .rst(rst),
        .flush(flush),
        .cpu_busy(cpu_busy),
        .out_pc(out_pc),
        .out_valid(out_valid),
        .out_hit(out_hit),
        .out_victim(out_victim),
        .wr(wr_bus.ctrl),
        .refill_line(refill_line),
        .busy(fetch_busy),
        .bus_arvalid(bus_arvalid),
        .bus_arready(bus_arready),
        .bus_araddr(bus_araddr),
        .bus_rlen(bus_rlen),
        .bus_rvalid(bus_rvalid),
        .bus_rdata(bus_rdata),
        .bus_rlast(bus_rlast),
        .bus_rready(bus_rready)
    );

endmodule

// File: bench/fetch_properties.sv
// bus handshake and clearing checks that the testbench binds onto every fetch_unit instance
`timescale 1ns/1ns

module fetch_properties (
    input logic           clk,
    input logic           rst,
    input logic           fetch_valid,
    input logic           fetch_busy,
    input logic           bus_arvalid,
    input logic           bus_arready,
    input ifu_pkg::word_t bus_araddr,
    input logic           bus_rvalid,
    input logic           bus_rlast,
    input logic           bus_rready
);

    // a burst was accepted and its last beat not yet taken
    logic xfer_open;
    logic clearing;
    int   assert_fails = 0;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            xfer_open <= 1'b0;
            clearing  <= 1'b1;
        end else begin
            if (bus_arvalid && bus_arready) begin
                xfer_open <= 1'b1;
            end else if (bus_rvalid && bus_rready && bus_rlast) begin
                xfer_open <= 1'b0;
            end
            if (!fetch_busy) begin
                clearing <= 1'b0;
            end
        end
    end

    // request and its address hold until the bus takes them
    arvalid_held: assert property (@(posedge clk) disable iff (rst)
        bus_arvalid && !bus_arready |=> bus_arvalid && $stable(bus_araddr))
        else begin
            assert_fails++;
            $error("bus_arvalid dropped or bus_araddr moved before acceptance");
        end

    rready_in_burst: assert property (@(posedge clk) disable iff (rst)
        bus_rready |-> xfer_open)
        else begin
            assert_fails++;
            $error("bus_rready high with no burst open");
        end

    no_fetch_while_clearing: assert property (@(posedge clk) disable iff (rst)
        clearing |-> !fetch_valid)
        else begin
            assert_fails++;
            $error("fetch_valid high while the cache is being cleared");
        end

endmodule

// File: bench/tb_fetch_unit.sv
// testbench for the fetch unit with a burst memory model, random stalls, flushes and a loop pass
`timescale 1ns/1ns
`include "ifu_params.svh"

module tb_fetch_unit;
    import ifu_pkg::*;

    localparam int    CLK_PERIOD   = 4;
    localparam int    LINE_BYTES   = `IFU_WORDS_PER_LINE * 4;
    localparam int    SEQ_FETCHES  = 40;
    localparam int    LOOP_WORDS   = 16;
    localparam word_t LOOP_BASE    = 32'h8000_4000;
    localparam word_t LOOP_LAST    = LOOP_BASE + 4 * (LOOP_WORDS - 1);
    localparam word_t RAND_BASE    = 32'h8001_0000;
    localparam int    FLUSH_ROUNDS = 6;
    localparam int    ROUND_MAX    = 12;
    localparam int    TAIL_FETCHES = 8;
    localparam int    PLANNED      = SEQ_FETCHES + 2 * LOOP_WORDS
                                     + FLUSH_ROUNDS * ROUND_MAX + TAIL_FETCHES;
    // cycles allowed per fetch to cover a refill with long bus gaps
    localparam int    REFILL_BOUND = 64;
    localparam int    WATCHDOG_NS  = (PLANNED * REFILL_BOUND + `IFU_NUM_SETS + 8) * CLK_PERIOD;

    logic       clk = 1'b0;
    logic       rst;
    logic       flush;
    word_t      redirect_pc;
    logic       cpu_busy;
    word_t      fetch_pc;
    word_t      fetch_inst;
    logic       fetch_valid;
    logic       fetch_busy;
    logic       bus_arvalid;
    logic       bus_arready;
    word_t      bus_araddr;
    logic [3:0] bus_rlen;
    logic       bus_rvalid;
    word_t      bus_rdata;
    logic       bus_rlast;
    logic       bus_rready;

    int          taken_count = 0;
    int          req_count = 0;
    int          req_before;
    int          busy_cycles;
    word_t       exp_pc = `IFU_RESET_PC;
    // previous sample for the back-pressure hold check
    logic        prev_hold = 1'b0;
    word_t       prev_pc;
    word_t       prev_inst;
    logic        prev_valid;
    // memory model burst state
    word_t       burst_addr;
    int          beat_idx;
    logic        burst_open = 1'b0;
    logic        in_reset;

    always #(CLK_PERIOD / 2) clk = ~clk;

    fetch_unit u_fetch_unit (
        .clk(clk),
        .rst(rst),
        .flush(flush),
        .redirect_pc(redirect_pc),
        .cpu_busy(cpu_busy),
        .fetch_pc(fetch_pc),
        .fetch_inst(fetch_inst),
        .fetch_valid(fetch_valid),
        .fetch_busy(fetch_busy),
        .bus_arvalid(bus_arvalid),
        .bus_arready(bus_arready),
        .bus_araddr(bus_araddr),
        .bus_rlen(bus_rlen),
        .bus_rvalid(bus_rvalid),
        .bus_rdata(bus_rdata),
        .bus_rlast(bus_rlast),
        .bus_rready(bus_rready)
    );

    bind fetch_unit fetch_properties u_fetch_properties (
        .clk(clk),
        .rst(rst),
        .fetch_valid(fetch_valid),
        .fetch_busy(fetch_busy),
        .bus_arvalid(bus_arvalid),
        .bus_arready(bus_arready),
        .bus_araddr(bus_araddr),
        .bus_rvalid(bus_rvalid),
        .bus_rlast(bus_rlast),
        .bus_rready(bus_rready)
    );

    // program image with bit 5 forced so no word reads as a nop
    function automatic word_t mem_word(input word_t addr);
        word_t h;
        h = addr * 32'h9e37_79b9;
        h = h ^ {h[15:0], h[31:16]};
        return h | 32'h0000_0020;
    endfunction

    task automatic stop_run();
        $display("Regression failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("Fail %s: got 0x%08h, expected 0x%08h", name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Fail %s: got 0x%0h, expected 0x%0h", name, got, exp);
            stop_run();
        end
    endtask

    // returns on a rising edge once n more instructions were taken
    task automatic wait_fetches(input int n);
        int target;
        target = taken_count + n;
        while (taken_count < target) begin
            @(posedge clk);
        end
    endtask

    // returns at the falling edge where pc is taken by the cpu
    task automatic wait_taken_pc(input word_t pc);
        do begin
            @(negedge clk);
        end while (!(fetch_valid && !cpu_busy && fetch_pc == pc));
    endtask

    task automatic issue_flush(input word_t target);
        @(posedge clk);
        flush       <= 1'b1;
        redirect_pc <= target;
        @(posedge clk);
        flush       <= 1'b0;
    endtask

    // burst memory and random cpu stalls
    always begin
        @(negedge clk);
        in_reset = rst;
        if (bus_arvalid && bus_arready) begin
            check_word("bus_araddr", bus_araddr, bus_araddr & ~word_t'(LINE_BYTES - 1));
            check_word("bus_rlen", word_t'(bus_rlen), word_t'(`IFU_WORDS_PER_LINE));
            burst_addr = bus_araddr;
            beat_idx   = 0;
            burst_open = 1'b1;
            req_count++;
        end
        if (bus_rvalid && bus_rready) begin
            beat_idx++;
            if (bus_rlast) begin
                burst_open = 1'b0;
            end
        end
        @(posedge clk);
        bus_arready <= ($urandom % 4) != 0;
        cpu_busy    <= !in_reset && ($urandom % 5) == 0;
        if (burst_open && ($urandom % 4) != 0) begin
            bus_rvalid <= 1'b1;
            bus_rdata  <= mem_word(burst_addr + word_t'(beat_idx * 4));
            bus_rlast  <= beat_idx == `IFU_WORDS_PER_LINE - 1;
        end else begin
            bus_rvalid <= 1'b0;
            bus_rlast  <= 1'b0;
        end
    end

    // compare every taken instruction against the program order and image
    always @(negedge clk) begin
        if (u_fetch_unit.u_fetch_properties.assert_fails != 0) begin
            $display("a bound assertion on the bus or busy behavior failed");
            stop_run();
        end
        if (!rst) begin
            if (flush) begin
                exp_pc = redirect_pc;
            end else if (fetch_valid && !cpu_busy) begin
                check_word("fetch_pc", fetch_pc, exp_pc);
                check_word("fetch_inst", fetch_inst, mem_word(fetch_pc));
                exp_pc = exp_pc + 32'd4;
                taken_count++;
            end
            // no valid instruction shows as a nop
            if (!fetch_valid) begin
                check_word("fetch_inst", fetch_inst, `IFU_NOP);
            end
            if (prev_hold && cpu_busy && !flush) begin
                check_word("fetch_pc", fetch_pc, prev_pc);
                check_word("fetch_inst", fetch_inst, prev_inst);
                check_bit("fetch_valid", fetch_valid, prev_valid);
            end
            prev_hold  = cpu_busy && !flush;
            prev_pc    = fetch_pc;
            prev_inst  = fetch_inst;
            prev_valid = fetch_valid;
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired with %0d of %0d planned fetches taken", taken_count, PLANNED);
        stop_run();
    end

    initial begin
        void'($urandom(72129));
        rst         = 1'b1;
        flush       = 1'b0;
        redirect_pc = '0;
        cpu_busy    = 1'b0;
        bus_arready = 1'b0;
        bus_rvalid  = 1'b0;
        bus_rdata   = '0;
        bus_rlast   = 1'b0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;

        // cache clearing keeps the unit busy for about one cycle per set
        @(negedge clk);
        check_bit("fetch_busy", fetch_busy, 1'b1);
        busy_cycles = 0;
        while (fetch_busy) begin
            busy_cycles++;
            @(negedge clk);
        end
        if (busy_cycles < `IFU_NUM_SETS - 1) begin
            $display("fetch_busy fell after %0d cycles, before all sets were cleared",
                     busy_cycles);
            stop_run();
        end

        wait_fetches(SEQ_FETCHES);

        // loop fetched once and then again with no bus traffic
        issue_flush(LOOP_BASE);
        wait_taken_pc(LOOP_LAST);
        issue_flush(LOOP_BASE);
        req_before = req_count;
        wait_taken_pc(LOOP_LAST);
        issue_flush(RAND_BASE);
        if (req_count != req_before) begin
            $display("second pass over the cached loop issued %0d bus requests",
                     req_count - req_before);
            stop_run();
        end

        // flushes at random points that sometimes hit a refill
        repeat (FLUSH_ROUNDS) begin
            wait_fetches(3 + ($urandom % (ROUND_MAX - 2)));
            repeat ($urandom % 6) @(posedge clk);
            issue_flush(RAND_BASE + word_t'(($urandom % 1024) * 4));
        end
        wait_fetches(TAIL_FETCHES);

        @(negedge clk);
        if (u_fetch_unit.u_fetch_properties.assert_fails == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: files.f
+incdir+source
source/ifu_pkg.sv
source/icache_wr_if.sv
source/sync_ram.sv
source/icache_store.sv
source/fetch_pipe.sv
source/refill_ctrl.sv
source/fetch_unit.sv
bench/fetch_properties.sv
bench/tb_fetch_unit.sv

// File: Bender.yml
package:
  name: fetch_unit

sources:
  - include_dirs:
      - source
    files:
      - source/ifu_pkg.sv
      - source/icache_wr_if.sv
      - source/sync_ram.sv
      - source/icache_store.sv
      - source/fetch_pipe.sv
      - source/refill_ctrl.sv
      - source/fetch_unit.sv
  - target: test
    include_dirs:
      - source
    files:
      - bench/fetch_properties.sv
      - bench/tb_fetch_unit.sv
